//--- Bender.yml
package:
  name: div_pipe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/div_pkg.sv
      - rtl/div_radix16_stage.sv
      - rtl/div_prep.sv
      - rtl/div_iter_pipe.sv
      - rtl/div_post.sv
      - rtl/div_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/div_chk.sv
      - verif/div_tb.sv

//--- all.f
+incdir+rtl
rtl/div_pkg.sv
rtl/div_radix16_stage.sv
rtl/div_prep.sv
rtl/div_iter_pipe.sv
rtl/div_post.sv
rtl/div_top.sv
verif/div_chk.sv
verif/div_tb.sv

//--- rtl/div_cfg.svh
// --------------------------------------------------------------------------
// divider configuration macros: operand width, radix-16 stages per register
// --------------------------------------------------------------------------
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result width, stage logic is built around 64
`define DIV_WIDTH 64

// radix-16 stages per pipeline register, must divide 16 (1, 2, 4)
`define DIV_STAGES_PER_CYCLE 2

`endif

//--- rtl/div_iter_pipe.sv
// --------------------------------------------------------------------------
// one registered iteration step made of chained radix-16 stages
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_iter_pipe #(
    parameter int first_stage = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  div_pkg::div_pipe_t in,
    output logic               out_valid,
    output div_pkg::div_pipe_t out
);

    import div_pkg::*;

    localparam int n_stages = `DIV_STAGES_PER_CYCLE;

    logic [63:0]  resid_chain [0:n_stages];
    logic [123:0] dvs_shift [0:n_stages-1];
    logic [3:0]   digit [0:n_stages-1];
    div_pipe_t    nxt;

    assign resid_chain[0] = in.resid;

    for (genvar i = 0; i < n_stages; i++) begin : g_stage
        // stage first_stage+i resolves digit 15-first_stage-i
        assign dvs_shift[i] = {60'd0, in.divisor_abs} << (4 * (15 - first_stage - i));

        div_radix16_stage stage_i (
            .resid      (resid_chain[i]),
            .divisor    (dvs_shift[i]),
            .resid_next (resid_chain[i+1]),
            .bits       (digit[i])
        );
    end

    always_comb begin
        nxt       = in;
        nxt.resid = resid_chain[n_stages];
        // most significant digit enters first and ends up on top
        for (int i = 0; i < n_stages; i++) begin
            nxt.quot = {nxt.quot[59:0], digit[i]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= nxt;
        end
    end

endmodule

//--- rtl/div_pkg.sv
// --------------------------------------------------------------------------
// divider types: operation enum, request, pipeline state, result word
// --------------------------------------------------------------------------
`include "div_cfg.svh"

package div_pkg;

    typedef enum logic [1:0] {
        op_divu = 2'd0,
        op_div  = 2'd1,
        op_remu = 2'd2,
        op_rem  = 2'd3
    } div_op_e;

    typedef struct packed {
        div_op_e                op;
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
    } div_req_t;

    // state handed from one pipeline register to the next
    typedef struct packed {
        div_op_e                op;
        logic                   neg_q;
        logic                   neg_r;
        logic                   div_zero;
        logic [`DIV_WIDTH-1:0] dividend_orig;
        logic [`DIV_WIDTH-1:0] resid;
        logic [`DIV_WIDTH-1:0] quot;
        logic [`DIV_WIDTH-1:0] divisor_abs;
    } div_pipe_t;

    typedef logic [`DIV_WIDTH-1:0] div_res_t;

endpackage

//--- rtl/div_post.sv
// --------------------------------------------------------------------------
// last divider register: sign fix, divide-by-zero override, result select
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module div_post (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  div_pkg::div_pipe_t in,
    output logic               res_valid,
    output div_pkg::div_res_t  res
);

    import div_pkg::*;

    logic [63:0] q_signed;
    logic [63:0] r_signed;
    logic [63:0] q_fix;
    logic [63:0] r_fix;
    div_res_t    res_nxt;

    assign q_signed = in.neg_q ? -in.quot : in.quot;
    assign r_signed = in.neg_r ? -in.resid : in.resid;

    // RISC-V rule for x/0: all ones quotient, dividend as remainder
    assign q_fix = in.div_zero ? '1 : q_signed;
    assign r_fix = in.div_zero ? in.dividend_orig : r_signed;

    assign res_nxt = (in.op inside {op_remu, op_rem}) ? r_fix : q_fix;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            res <= res_nxt;
        end
    end

endmodule

//--- rtl/div_prep.sv
// --------------------------------------------------------------------------
// first divider register: operation decode, magnitudes, sign and zero flags
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module div_prep (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  div_pkg::div_req_t  req,
    output logic               out_valid,
    output div_pkg::div_pipe_t out
);

    import div_pkg::*;

    logic      is_signed;
    logic      sgn_a;
    logic      sgn_b;
    div_pipe_t nxt;

    assign is_signed = (req.op == op_div) || (req.op == op_rem);

    // operand signs only count for div and rem
    assign sgn_a = is_signed & req.dividend[63];
    assign sgn_b = is_signed & req.divisor[63];

    always_comb begin
        nxt               = '0;
        nxt.op            = req.op;
        nxt.neg_q         = sgn_a ^ sgn_b;
        nxt.neg_r         = sgn_a;
        nxt.div_zero      = (req.divisor == '0);
        nxt.dividend_orig = req.dividend;
        // most negative value maps onto itself, read as unsigned 2^63
        nxt.resid         = sgn_a ? -req.dividend : req.dividend;
        nxt.divisor_abs   = sgn_b ? -req.divisor : req.divisor;
        nxt.quot          = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            out <= nxt;
        end
    end

endmodule

//--- rtl/div_radix16_stage.sv
// --------------------------------------------------------------------------
// combinational radix-16 division step: one quotient digit per call
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module div_radix16_stage (
    input  logic [63:0]  resid,
    input  logic [123:0] divisor,
    output logic [63:0]  resid_next,
    output logic [3:0]   bits
);

    // any bit above 63 means even one times the divisor is out of reach
    logic        dvs_big;
    logic [67:0] mult [1:15];
    logic [64:0] diff [1:15];
    logic        too_big [1:15];

    assign dvs_big = |divisor[123:64];

    // multiples of the low 64 divisor bits, 68 bits wide so x15 fits
    always_comb begin
        mult[1]  = {4'd0, divisor[63:0]};
        mult[2]  = mult[1] << 1;
        mult[4]  = mult[1] << 2;
        mult[8]  = mult[1] << 3;
        // 3 = 2 + 1
        mult[3]  = mult[2] + mult[1];
        // 5 = 4 + 1
        mult[5]  = mult[4] + mult[1];
        mult[6]  = mult[3] << 1;
        // 7 = 8 - 1
        mult[7]  = mult[8] - mult[1];
        mult[9]  = mult[8] + mult[1];
        mult[10] = mult[5] << 1;
        mult[11] = mult[8] + mult[3];
        mult[12] = mult[3] << 2;
        // 13 and 15 come down from 16
        mult[13] = (mult[1] << 4) - mult[3];
        mult[14] = mult[7] << 1;
        mult[15] = (mult[1] << 4) - mult[1];
    end

    // trial subtraction against every multiple
    always_comb begin
        for (int k = 1; k < 16; k++) begin
            diff[k]    = {1'b0, resid} - {1'b0, mult[k][63:0]};
            // multiple beyond 64 bits, or remainder would go negative
            too_big[k] = dvs_big | (|mult[k][67:64]) | diff[k][64];
        end
    end

    // fits are monotonic in k, so the last fit found is the largest digit
    always_comb begin
        bits       = 4'd0;
        resid_next = resid;
        for (int k = 1; k < 16; k++) begin
            if (!too_big[k]) begin
                bits       = 4'(k);
                resid_next = diff[k][63:0];
            end
        end
    end

endmodule

//--- rtl/div_top.sv
// --------------------------------------------------------------------------
// pipelined 64-bit divider top: prep, iteration steps, post
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  div_pkg::div_req_t req,
    output logic              res_valid,
    output div_pkg::div_res_t res
);

    import div_pkg::*;

    localparam int n_steps = 16 / `DIV_STAGES_PER_CYCLE;

    // entry 0 is the prep output, entry n_steps feeds post
    logic      step_valid [0:n_steps];
    div_pipe_t step_data [0:n_steps];

    div_prep prep_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .out_valid (step_valid[0]),
        .out       (step_data[0])
    );

    for (genvar s = 0; s < n_steps; s++) begin : g_step
        div_iter_pipe #(
            .first_stage (s * `DIV_STAGES_PER_CYCLE)
        ) iter_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (step_valid[s]),
            .in        (step_data[s]),
            .out_valid (step_valid[s+1]),
            .out       (step_data[s+1])
        );
    end

    div_post post_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (step_valid[n_steps]),
        .in        (step_data[n_steps]),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

//--- verif/div_chk.sv
// --------------------------------------------------------------------------
// divider assertions bound to div_top: reset behaviour and result timing
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module div_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        req_valid,
    input logic        res_valid,
    input logic [63:0] res
);

    // number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // valid registers stay cleared while reset is held
    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !res_valid)
        else begin
            $error("res_valid high during reset");
            fail_count++;
        end

    // every request comes out exactly ten cycles later
    a_req_to_res: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> ##10 res_valid)
        else begin
            $error("request without a result ten cycles later");
            fail_count++;
        end

    // and every result has a request ten cycles before it
    a_res_from_req: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> $past(req_valid, 10))
        else begin
            $error("result without a request ten cycles earlier");
            fail_count++;
        end

    a_res_known: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> !$isunknown(res))
        else begin
            $error("unknown bits on res while res_valid is high");
            fail_count++;
        end

endmodule

bind div_top div_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .res_valid (res_valid),
    .res       (res)
);

//--- verif/div_tb.sv
// --------------------------------------------------------------------------
// divider testbench: random requests, reference model, in-order scoreboard
// with latency and q*d+r checks, watchdog and summary
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_tb;

    import div_pkg::*;

    localparam int n_unsigned  = 150;
    localparam int n_signed    = 150;
    localparam int n_zero      = 40;
    localparam int n_ovf       = 20;
    localparam int n_burst     = 200;
    localparam int total_reqs  = n_unsigned + n_signed + n_zero + n_ovf + n_burst;
    localparam int watchdog_ns = (total_reqs + 20) * 20 * 2;
    localparam int latency     = 10;
    localparam logic [`DIV_WIDTH-1:0] min_val = {1'b1, {(`DIV_WIDTH-1){1'b0}}};

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    div_req_t req;
    logic     res_valid;
    div_res_t res;

    integer   seed;
    int       cycle;
    int       n_reqs;
    int       n_checks;
    int       n_errors;
    int       mark_reqs;
    int       mark_errs;
    int       total_fail;

    // expected word, issuing request and the edge that took it
    logic [`DIV_WIDTH-1:0] exp_q [$];
    div_req_t              sent_q [$];
    int                    edge_q [$];

    // last division result to pair with the remainder that follows it
    logic                  pair_ok;
    div_req_t              pair_req;
    logic [`DIV_WIDTH-1:0] pair_q;

    div_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // reference model of the RISC-V divide rules in plain operators
    function automatic logic [`DIV_WIDTH-1:0] model_result(div_req_t r);
        logic signed [`DIV_WIDTH-1:0] sa;
        logic signed [`DIV_WIDTH-1:0] sb;
        logic                         ovf;
        sa  = r.dividend;
        sb  = r.divisor;
        ovf = (r.dividend == min_val) && (r.divisor == '1);
        if (r.divisor == '0) begin
            if (r.op inside {op_divu, op_div}) return '1;
            return r.dividend;
        end
        case (r.op)
            op_divu: return r.dividend / r.divisor;
            op_remu: return r.dividend % r.divisor;
            op_div: begin
                if (ovf) return r.dividend;
                return sa / sb;
            end
            default: begin
                if (ovf) return '0;
                return sa % sb;
            end
        endcase
    endfunction

    // operands lean toward the corner values
    function automatic logic [`DIV_WIDTH-1:0] pick_operand();
        int v;
        v = $random(seed);
        case (v & 7)
            0: return '0;
            1: return 64'd1;
            2: return '1;
            3: return min_val;
            4: return {48'd0, v[31:16]};
            5: return {{32{v[30]}}, v[30:0], v[31]};
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            req_valid = 1'b0;
        end
    endtask

    task automatic send_request(input div_op_e op, input logic [`DIV_WIDTH-1:0] a,
                                input logic [`DIV_WIDTH-1:0] b);
        div_req_t r;
        r = '{op: op, dividend: a, divisor: b};
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(model_result(r));
        sent_q.push_back(r);
        edge_q.push_back(cycle + 1);
        n_reqs++;
    endtask

    task automatic send_pairs(input div_op_e q_op, input int n);
        logic [`DIV_WIDTH-1:0] a;
        logic [`DIV_WIDTH-1:0] b;
        repeat (n) begin
            a = pick_operand();
            b = pick_operand();
            send_request(q_op, a, b);
            send_request(div_op_e'(q_op ^ 2'b10), a, b);
            if (($random(seed) & 3) == 0) drive_idle(1);
        end
    endtask

    task automatic check_result();
        logic [`DIV_WIDTH-1:0] exp;
        div_req_t              r;
        int                    lat;
        exp = exp_q.pop_front();
        r   = sent_q.pop_front();
        lat = cycle + 1 - edge_q.pop_front();
        n_checks++;
        if (res !== exp) begin
            $display("** Error: res expected %h got %h (op %0d, a %h, b %h)",
                     exp, res, r.op, r.dividend, r.divisor);
            n_errors++;
        end
        if (lat != latency) begin
            $display("result arrived after %0d cycles instead of %0d", lat, latency);
            n_errors++;
        end
        // q*d+r == a holds modulo 2^64 for every op pair including x/0 and overflow
        if (pair_ok && r.op inside {op_remu, op_rem} && pair_req.op == (r.op ^ 2'b10) &&
            pair_req.dividend == r.dividend && pair_req.divisor == r.divisor) begin
            if (pair_q * r.divisor + res !== r.dividend) begin
                $display("** Error: res q*d+r expected %h got %h",
                         r.dividend, pair_q * r.divisor + res);
                n_errors++;
            end
        end
        pair_ok  = r.op inside {op_divu, op_div};
        pair_req = r;
        pair_q   = res;
    endtask

    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("res_valid high at cycle %0d with no request outstanding", cycle);
                n_errors++;
            end else begin
                check_result();
            end
        end
    end

    task automatic end_test(input string name);
        int guard;
        guard = 0;
        while (exp_q.size() != 0 && guard < 15) begin
            drive_idle(1);
            guard++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d requests never produced a result", exp_q.size());
            n_errors++;
            exp_q.delete();
            sent_q.delete();
            edge_q.delete();
        end
        drive_idle(1);
        $display("test %-18s requests %4d  errors %0d", name, n_reqs - mark_reqs,
                 n_errors - mark_errs);
        mark_reqs = n_reqs;
        mark_errs = n_errors;
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed      = 27700;
        cycle     = 0;
        n_reqs    = 0;
        n_checks  = 0;
        n_errors  = 0;
        mark_reqs = 0;
        mark_errs = 0;
        pair_ok   = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        drive_idle(15);
        end_test("idle after reset");
        send_pairs(op_divu, n_unsigned / 2);
        end_test("unsigned random");
        send_pairs(op_div, n_signed / 2);
        end_test("signed random");
        repeat (n_zero / 4) begin
            send_request(op_divu, {$random(seed), $random(seed)}, '0);
            send_request(op_remu, req.dividend, '0);
            send_request(op_div, req.dividend, '0);
            send_request(op_rem, req.dividend, '0);
        end
        end_test("divide by zero");
        for (int i = 0; i < n_ovf / 2; i++) begin
            send_request((i % 2 == 0) ? op_div : op_divu, min_val, '1);
            send_request((i % 2 == 0) ? op_rem : op_remu, min_val, '1);
        end
        end_test("signed overflow");
        repeat (n_burst) begin
            send_request(div_op_e'(2'($random(seed))), pick_operand(), pick_operand());
        end
        end_test("back to back");

        total_fail = n_errors + dut_i.chk_i.fail_count;
        $display("results checked %0d, requests %0d, errors %0d, assertion failures %0d",
                 n_checks, n_reqs, n_errors, dut_i.chk_i.fail_count);
        if (total_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
